// ==== design/l2_msg_pkg.sv ====
package l2_msg_pkg;

    // Requests from the core side.
    typedef enum logic {
        CPU_READ,
        CPU_WRITE
    } cpu_msg_t;

    // Coherence messages forwarded from the directory.
    typedef enum logic [2:0] {
        FWD_INV,
        FWD_INV_LLC,
        FWD_GETS,
        FWD_GETM,
        FWD_PUTACK
    } fwd_msg_t;

    // Transient states of a buffered miss.
    // INVALID marks a free entry.
    typedef enum logic [1:0] {
        INVALID,
        ISD,  // Read miss waiting for data.
        IMAD, // Write miss waiting for data.
        MIA   // Writeback waiting for its ack.
    } unstable_state_t;

    // Search operations the controller can start in the request buffer.
    typedef enum logic [1:0] {
        REQS_IDLE,
        REQS_LOOKUP,
        REQS_PEEK_REQ,
        REQS_PEEK_FWD
    } reqs_op_t;

endpackage

// ==== design/l2_cache_pkg.sv ====
package l2_cache_pkg;

    // Address layout, from the top bit down: tag, set index, word offset, byte offset.
    localparam int ADDR_BITS = 32;
    localparam int SET_BITS = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int W_OFF_BITS = 2;
    localparam int TAG_BITS = 24; // The two bits left below the word offset select a byte.

    typedef logic [ADDR_BITS-1:0] addr_t;

    typedef logic [TAG_BITS-1:0] l2_tag_t;
    typedef logic [SET_BITS-1:0] l2_set_t;
    typedef logic [W_OFF_BITS-1:0] w_off_t;

    typedef logic [31:0] word_t;

    // Word 0 of a line sits in the low bits.
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // One miss held in the request buffer.
    // The message and state types come from the message package.
    typedef struct packed {
        l2_msg_pkg::cpu_msg_t cpu_msg;
        l2_tag_t tag;
        l2_set_t set;
        w_off_t w_off;
        word_t word; // Store data for a write miss.
        line_t line; // Line returned by memory.
        l2_msg_pkg::unstable_state_t state;
    } reqs_buf_t;

endpackage

// ==== design/l2_reqs_if.sv ====
`timescale 1ns/100ps

interface l2_reqs_if #(
    parameter int N_REQS = 4,
    localparam int IDX_BITS = (N_REQS > 1) ? $clog2(N_REQS) : 1
);
    import l2_cache_pkg::*;
    import l2_msg_pkg::*;

    reqs_op_t op;
    logic lookup_en;
    l2_tag_t key_tag;
    l2_set_t key_set;
    fwd_msg_t fwd_msg;

    // Entry writes, all aimed at the registered index.
    logic fill;
    cpu_msg_t cpu_msg;
    w_off_t w_off;
    word_t word;
    logic wr_state;
    unstable_state_t state_data;
    logic wr_line;
    line_t line_data;

    logic [IDX_BITS-1:0] reqs_i;
    logic reqs_hit;
    logic set_conflict;
    logic full;
    logic set_fwd_stall;
    logic clr_fwd_stall;
    reqs_buf_t entry_o;

    modport ctrl (
        output op, lookup_en, key_tag, key_set, fwd_msg,
        output fill, cpu_msg, w_off, word, wr_state, state_data, wr_line, line_data,
        input reqs_i, reqs_hit, set_conflict, full, set_fwd_stall, clr_fwd_stall, entry_o
    );

    modport buffer (
        input op, lookup_en, key_tag, key_set, fwd_msg,
        input fill, cpu_msg, w_off, word, wr_state, state_data, wr_line, line_data,
        output reqs_i, reqs_hit, set_conflict, full, set_fwd_stall, clr_fwd_stall, entry_o
    );

endinterface

// ==== design/l2_reqs.sv ====
`timescale 1ns/100ps

module l2_reqs #(
    parameter int N_REQS = 4,
    localparam int IDX_BITS = (N_REQS > 1) ? $clog2(N_REQS) : 1
) (
    input logic clk,
    input logic rst,
    l2_reqs_if.buffer reqs_bus
);
    import l2_cache_pkg::*;
    import l2_msg_pkg::*;

    reqs_buf_t entries [N_REQS];

    logic [IDX_BITS-1:0] reqs_i_next;
    logic hit_next;
    logic conflict_next;
    logic full_next;
    logic set_stall_next;
    logic clr_stall_next;

    // Only the state is cleared, so every entry comes out of reset free.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < N_REQS; i++) begin
                entries[i].state <= INVALID;
            end
        end else begin
            for (int i = 0; i < N_REQS; i++) begin
                if (reqs_bus.reqs_i == IDX_BITS'(i)) begin
                    if (reqs_bus.fill) begin
                        entries[i].cpu_msg <= reqs_bus.cpu_msg;
                        entries[i].tag <= reqs_bus.key_tag;
                        entries[i].set <= reqs_bus.key_set;
                        entries[i].w_off <= reqs_bus.w_off;
                        entries[i].word <= reqs_bus.word;
                        entries[i].line <= '0; // The line itself comes later from memory.
                        entries[i].state <= reqs_bus.state_data;
                    end else begin
                        if (reqs_bus.wr_state) begin
                            entries[i].state <= reqs_bus.state_data;
                        end
                        if (reqs_bus.wr_line) begin
                            entries[i].line <= reqs_bus.line_data;
                        end
                    end
                end
            end
        end
    end

    // Each loop runs upward, so the highest matching index wins.
    always_comb begin
        reqs_i_next = '0;
        hit_next = 1'b0;
        conflict_next = 1'b0;
        full_next = 1'b0;
        set_stall_next = 1'b0;
        clr_stall_next = 1'b0;
        case (reqs_bus.op)
            REQS_LOOKUP: begin
                for (int i = 0; i < N_REQS; i++) begin
                    if (entries[i].state != INVALID && entries[i].tag == reqs_bus.key_tag &&
                        entries[i].set == reqs_bus.key_set) begin
                        reqs_i_next = IDX_BITS'(i);
                        hit_next = 1'b1;
                    end
                end
            end
            REQS_PEEK_REQ: begin
                full_next = 1'b1;
                for (int i = 0; i < N_REQS; i++) begin
                    if (entries[i].state == INVALID) begin
                        reqs_i_next = IDX_BITS'(i);
                        full_next = 1'b0;
                    end else if (entries[i].set == reqs_bus.key_set) begin
                        conflict_next = 1'b1; // One miss per set at a time.
                    end
                end
            end
            REQS_PEEK_FWD: begin
                for (int i = 0; i < N_REQS; i++) begin
                    if (entries[i].state != INVALID && entries[i].tag == reqs_bus.key_tag &&
                        entries[i].set == reqs_bus.key_set) begin
                        reqs_i_next = IDX_BITS'(i);
                        hit_next = 1'b1;
                        set_stall_next = 1'b1;
                        clr_stall_next = 1'b0;
                        if (reqs_bus.fwd_msg == FWD_PUTACK) begin
                            set_stall_next = 1'b0;
                            clr_stall_next = 1'b1;
                        end else if (reqs_bus.fwd_msg == FWD_INV ||
                                     reqs_bus.fwd_msg == FWD_INV_LLC) begin
                            // An invalidation only has to wait behind a pending read.
                            if (entries[i].state != ISD) begin
                                set_stall_next = 1'b0;
                                clr_stall_next = 1'b1;
                            end
                        end else if (entries[i].state == MIA) begin
                            set_stall_next = 1'b0;
                            clr_stall_next = 1'b1;
                        end
                    end
                end
            end
            default: begin
                hit_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            reqs_bus.reqs_i <= '0;
            reqs_bus.reqs_hit <= 1'b0;
            reqs_bus.set_conflict <= 1'b0;
            reqs_bus.full <= 1'b0;
            reqs_bus.set_fwd_stall <= 1'b0;
            reqs_bus.clr_fwd_stall <= 1'b0;
        end else if (reqs_bus.lookup_en) begin
            reqs_bus.reqs_i <= reqs_i_next;
            reqs_bus.reqs_hit <= hit_next;
            reqs_bus.set_conflict <= conflict_next;
            reqs_bus.full <= full_next;
            reqs_bus.set_fwd_stall <= set_stall_next;
            reqs_bus.clr_fwd_stall <= clr_stall_next;
        end
    end

    assign reqs_bus.entry_o = entries[reqs_bus.reqs_i];

endmodule

// ==== design/l2_req_ctrl.sv ====
`timescale 1ns/100ps

module l2_req_ctrl #(
    parameter int N_REQS = 4,
    localparam int IDX_BITS = (N_REQS > 1) ? $clog2(N_REQS) : 1
) (
    input logic clk,
    input logic rst,

    input logic cpu_valid_i,
    output logic cpu_ready_o,
    input l2_msg_pkg::cpu_msg_t cpu_msg_i,
    input l2_cache_pkg::addr_t cpu_addr_i,
    input l2_cache_pkg::word_t cpu_word_i,

    input logic mem_valid_i,
    output logic mem_ready_o,
    input l2_cache_pkg::addr_t mem_addr_i,
    input l2_cache_pkg::line_t mem_line_i,

    input logic fwd_valid_i,
    output logic fwd_ready_o,
    input l2_msg_pkg::fwd_msg_t fwd_msg_i,
    input l2_cache_pkg::addr_t fwd_addr_i,

    output logic done_valid_o,
    output l2_cache_pkg::word_t done_word_o,
    output logic fwd_stall_o,
    output logic [IDX_BITS-1:0] fwd_stall_idx_o,

    l2_reqs_if.ctrl reqs_bus
);
    import l2_cache_pkg::*;
    import l2_msg_pkg::*;

    localparam int B_OFF_BITS = ADDR_BITS - TAG_BITS - SET_BITS - W_OFF_BITS;

    typedef enum logic [2:0] {
        IDLE,
        CPU_PEEK,
        CPU_FILL,
        MEM_LOOK,
        MEM_RETIRE,
        FWD_PEEK,
        FWD_APPLY
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t key_addr;
    logic cpu_accept;
    word_t done_word_d;

    // The search key follows whichever stream is being served.
    always_comb begin
        case (state_q)
            MEM_LOOK, MEM_RETIRE: key_addr = mem_addr_i;
            FWD_PEEK, FWD_APPLY: key_addr = fwd_addr_i;
            default: key_addr = cpu_addr_i;
        endcase
    end

    assign reqs_bus.key_tag = key_addr[ADDR_BITS-1 -: TAG_BITS];
    assign reqs_bus.key_set = key_addr[B_OFF_BITS + W_OFF_BITS +: SET_BITS];
    assign reqs_bus.w_off = cpu_addr_i[B_OFF_BITS +: W_OFF_BITS];
    assign reqs_bus.cpu_msg = cpu_msg_i;
    assign reqs_bus.word = cpu_word_i;
    assign reqs_bus.fwd_msg = fwd_msg_i;
    assign reqs_bus.line_data = mem_line_i;

    // A fill waiting at the same time takes the free entry question first.
    assign cpu_accept = !reqs_bus.set_conflict && !reqs_bus.full && !mem_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (mem_valid_i) begin
                    state_d = MEM_LOOK;
                end else if (fwd_valid_i) begin
                    state_d = FWD_PEEK;
                end else if (cpu_valid_i) begin
                    state_d = CPU_PEEK;
                end
            end
            CPU_PEEK: state_d = CPU_FILL;
            CPU_FILL: state_d = IDLE; // A refused request is simply tried again.
            MEM_LOOK: state_d = MEM_RETIRE;
            MEM_RETIRE: state_d = IDLE;
            FWD_PEEK: state_d = FWD_APPLY;
            FWD_APPLY: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_comb begin
        reqs_bus.op = REQS_IDLE;
        reqs_bus.lookup_en = 1'b0;
        reqs_bus.fill = 1'b0;
        reqs_bus.wr_state = 1'b0;
        reqs_bus.wr_line = 1'b0;
        reqs_bus.state_data = INVALID;
        cpu_ready_o = 1'b0;
        mem_ready_o = 1'b0;
        fwd_ready_o = 1'b0;
        case (state_q)
            CPU_PEEK: begin
                reqs_bus.op = REQS_PEEK_REQ;
                reqs_bus.lookup_en = 1'b1;
            end
            CPU_FILL: begin
                reqs_bus.state_data = (cpu_msg_i == CPU_READ) ? ISD : IMAD;
                reqs_bus.fill = cpu_accept;
                cpu_ready_o = cpu_accept;
            end
            MEM_LOOK: begin
                reqs_bus.op = REQS_LOOKUP;
                reqs_bus.lookup_en = 1'b1;
            end
            MEM_RETIRE: begin
                // Writing INVALID frees the entry. A fill with no owner is dropped.
                reqs_bus.wr_state = reqs_bus.reqs_hit;
                reqs_bus.wr_line = reqs_bus.reqs_hit;
                mem_ready_o = 1'b1;
            end
            FWD_PEEK: begin
                reqs_bus.op = REQS_PEEK_FWD;
                reqs_bus.lookup_en = 1'b1;
            end
            FWD_APPLY: begin
                fwd_ready_o = 1'b1;
            end
            default: begin
                fwd_ready_o = 1'b0;
            end
        endcase
    end

    // Reads return the requested word of the new line, writes echo their own data.
    assign done_word_d = (reqs_bus.entry_o.cpu_msg == CPU_READ) ?
                         mem_line_i[reqs_bus.entry_o.w_off] : reqs_bus.entry_o.word;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            done_valid_o <= 1'b0;
            fwd_stall_o <= 1'b0;
            fwd_stall_idx_o <= '0;
        end else begin
            state_q <= state_d;
            done_valid_o <= (state_q == MEM_RETIRE) && reqs_bus.reqs_hit;
            if (state_q == FWD_APPLY) begin
                if (reqs_bus.set_fwd_stall) begin
                    fwd_stall_o <= 1'b1;
                    fwd_stall_idx_o <= reqs_bus.reqs_i;
                end else if (reqs_bus.clr_fwd_stall) begin
                    fwd_stall_o <= 1'b0;
                    fwd_stall_idx_o <= reqs_bus.reqs_i;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MEM_RETIRE) begin
            done_word_o <= done_word_d;
        end
    end

endmodule

// ==== design/l2_mshr_top.sv ====
`timescale 1ns/100ps

module l2_mshr_top #(
    parameter int N_REQS = 4,
    localparam int IDX_BITS = (N_REQS > 1) ? $clog2(N_REQS) : 1
) (
    input logic clk,
    input logic rst,

    input logic cpu_valid_i,
    output logic cpu_ready_o,
    input l2_msg_pkg::cpu_msg_t cpu_msg_i,
    input l2_cache_pkg::addr_t cpu_addr_i,
    input l2_cache_pkg::word_t cpu_word_i,

    input logic mem_valid_i,
    output logic mem_ready_o,
    input l2_cache_pkg::addr_t mem_addr_i,
    input l2_cache_pkg::line_t mem_line_i,

    input logic fwd_valid_i,
    output logic fwd_ready_o,
    input l2_msg_pkg::fwd_msg_t fwd_msg_i,
    input l2_cache_pkg::addr_t fwd_addr_i,

    output logic done_valid_o,
    output l2_cache_pkg::word_t done_word_o,
    output logic fwd_stall_o,
    output logic [IDX_BITS-1:0] fwd_stall_idx_o
);

    l2_reqs_if #(.N_REQS(N_REQS)) reqs_bus ();

    l2_req_ctrl #(.N_REQS(N_REQS)) l2_req_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .cpu_valid_i(cpu_valid_i),
        .cpu_ready_o(cpu_ready_o),
        .cpu_msg_i(cpu_msg_i),
        .cpu_addr_i(cpu_addr_i),
        .cpu_word_i(cpu_word_i),
        .mem_valid_i(mem_valid_i),
        .mem_ready_o(mem_ready_o),
        .mem_addr_i(mem_addr_i),
        .mem_line_i(mem_line_i),
        .fwd_valid_i(fwd_valid_i),
        .fwd_ready_o(fwd_ready_o),
        .fwd_msg_i(fwd_msg_i),
        .fwd_addr_i(fwd_addr_i),
        .done_valid_o(done_valid_o),
        .done_word_o(done_word_o),
        .fwd_stall_o(fwd_stall_o),
        .fwd_stall_idx_o(fwd_stall_idx_o),
        .reqs_bus(reqs_bus.ctrl)
    );

    l2_reqs #(.N_REQS(N_REQS)) l2_reqs_inst (
        .clk(clk),
        .rst(rst),
        .reqs_bus(reqs_bus.buffer)
    );

endmodule

// ==== sim/l2_mshr_clkgen.sv ====
`timescale 1ns/100ps

module l2_mshr_clkgen #(
    parameter int HALF_PERIOD = 20,
    parameter int RESET_CYCLES = 2,
    parameter int RELEASE_DLY = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset lets go just after an edge, like every other driven input.
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #RELEASE_DLY rst_o = 1'b1;
    end

endmodule

// ==== sim/l2_mshr_properties.sv ====
`timescale 1ns/100ps

module l2_mshr_properties (
    input logic clk,
    input logic rst,
    input logic cpu_valid_i,
    input logic cpu_ready_i,
    input l2_cache_pkg::addr_t cpu_addr_i,
    input logic mem_valid_i,
    input logic mem_ready_i,
    input l2_cache_pkg::addr_t mem_addr_i,
    input logic fwd_valid_i,
    input logic fwd_ready_i,
    input l2_cache_pkg::addr_t fwd_addr_i,
    input logic done_valid_i
);

    logic cpu_hold_bad = 1'b0;
    logic mem_hold_bad = 1'b0;
    logic fwd_hold_bad = 1'b0;
    logic done_len_bad = 1'b0;
    logic done_src_bad = 1'b0;
    logic cpu_yield_bad = 1'b0;
    logic any_failed;

    assign any_failed = cpu_hold_bad | mem_hold_bad | fwd_hold_bad | done_len_bad |
                        done_src_bad | cpu_yield_bad;

    cpu_hold: assert property (@(posedge clk) disable iff (!rst)
        cpu_valid_i && !cpu_ready_i |=> cpu_valid_i && $stable(cpu_addr_i))
        else begin
            cpu_hold_bad = 1'b1;
            $error("CPU request dropped or changed before it was accepted.");
        end

    mem_hold: assert property (@(posedge clk) disable iff (!rst)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i))
        else begin
            mem_hold_bad = 1'b1;
            $error("Memory fill dropped or changed before it was accepted.");
        end

    fwd_hold: assert property (@(posedge clk) disable iff (!rst)
        fwd_valid_i && !fwd_ready_i |=> fwd_valid_i && $stable(fwd_addr_i))
        else begin
            fwd_hold_bad = 1'b1;
            $error("Forward message dropped or changed before it was accepted.");
        end

    // A done pulse is exactly one cycle long.
    done_len: assert property (@(posedge clk) disable iff (!rst)
        done_valid_i |=> !done_valid_i)
        else begin
            done_len_bad = 1'b1;
            $error("Done pulse lasted more than one cycle.");
        end

    done_src: assert property (@(posedge clk) disable iff (!rst)
        done_valid_i |-> $past(mem_valid_i && mem_ready_i))
        else begin
            done_src_bad = 1'b1;
            $error("Done pulse without a memory fill accepted in the cycle before.");
        end

    cpu_yield: assert property (@(posedge clk) disable iff (!rst)
        mem_valid_i |-> !cpu_ready_i)
        else begin
            cpu_yield_bad = 1'b1;
            $error("CPU request accepted while a memory fill was pending.");
        end

endmodule

// ==== sim/l2_mshr_tb.sv ====
`timescale 1ns/100ps

module l2_mshr_tb;
    import l2_cache_pkg::*;
    import l2_msg_pkg::*;

    localparam int N_REQS = 4;
    localparam int IDX_BITS = (N_REQS > 1) ? $clog2(N_REQS) : 1;
    localparam int FIELDS = 7; // Columns per line in the data file.
    localparam int MAX_OPS = 64;
    localparam int CYCLES_PER_OP = 20;
    localparam int DRIVE_DLY = 2;
    localparam int HELD_CYCLES = 10; // How long a refused CPU request is watched.

    // Operation kinds in the first column of the data file.
    localparam int OP_CPU = 0;
    localparam int OP_CPU_HELD = 1;
    localparam int OP_CPU_RESUME = 2;
    localparam int OP_FILL = 3;
    localparam int OP_FILL_DROP = 4;
    localparam int OP_FWD = 5;

    logic clk;
    logic rst;
    logic cpu_valid_i;
    logic cpu_ready_o;
    cpu_msg_t cpu_msg_i;
    addr_t cpu_addr_i;
    word_t cpu_word_i;
    logic mem_valid_i;
    logic mem_ready_o;
    addr_t mem_addr_i;
    line_t mem_line_i;
    logic fwd_valid_i;
    logic fwd_ready_o;
    fwd_msg_t fwd_msg_i;
    addr_t fwd_addr_i;
    logic done_valid_o;
    word_t done_word_o;
    logic fwd_stall_o;
    logic [IDX_BITS-1:0] fwd_stall_idx_o;

    logic [127:0] op_mem [FIELDS*MAX_OPS];
    int n_ops = 0;
    int cycle_count = 0;

    l2_mshr_clkgen #(.HALF_PERIOD(20), .RESET_CYCLES(2)) l2_mshr_clkgen_inst (
        .clk_o(clk),
        .rst_o(rst)
    );

    l2_mshr_top #(.N_REQS(N_REQS)) l2_mshr_top_inst (.*);

    bind l2_mshr_top l2_mshr_properties props_inst (
        .clk(clk),
        .rst(rst),
        .cpu_valid_i(cpu_valid_i),
        .cpu_ready_i(cpu_ready_o),
        .cpu_addr_i(cpu_addr_i),
        .mem_valid_i(mem_valid_i),
        .mem_ready_i(mem_ready_o),
        .mem_addr_i(mem_addr_i),
        .fwd_valid_i(fwd_valid_i),
        .fwd_ready_i(fwd_ready_o),
        .fwd_addr_i(fwd_addr_i),
        .done_valid_i(done_valid_o)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at %0t.", $time);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_stall(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s = %b, expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input logic [IDX_BITS-1:0] got,
                             input logic [IDX_BITS-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s = %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic post_cpu(input cpu_msg_t msg, input addr_t addr, input word_t data);
        cpu_msg_i = msg;
        cpu_addr_i = addr;
        cpu_word_i = data;
        cpu_valid_i = 1'b1;
    endtask

    // Ready is sampled at the falling edge. The transfer is the next rising edge.
    task automatic await_cpu_accept();
        @(negedge clk);
        while (!cpu_ready_o) begin
            @(negedge clk);
        end
        next_drive_slot();
        cpu_valid_i = 1'b0;
    endtask

    task automatic send_fill(input addr_t addr, input line_t line);
        mem_addr_i = addr;
        mem_line_i = line;
        mem_valid_i = 1'b1;
        @(negedge clk);
        while (!mem_ready_o) begin
            @(negedge clk);
        end
        next_drive_slot();
        mem_valid_i = 1'b0;
    endtask

    task automatic send_fwd(input fwd_msg_t msg, input addr_t addr);
        fwd_msg_i = msg;
        fwd_addr_i = addr;
        fwd_valid_i = 1'b1;
        @(negedge clk);
        while (!fwd_ready_o) begin
            @(negedge clk);
        end
        next_drive_slot();
        fwd_valid_i = 1'b0;
    endtask

    task automatic run_op(input int base);
        int kind;
        kind = int'(op_mem[base][7:0]);
        case (kind)
            OP_CPU: begin
                post_cpu(cpu_msg_t'(op_mem[base+1][0]), op_mem[base+2][31:0],
                         op_mem[base+3][31:0]);
                await_cpu_accept();
            end
            OP_CPU_HELD: begin
                post_cpu(cpu_msg_t'(op_mem[base+1][0]), op_mem[base+2][31:0],
                         op_mem[base+3][31:0]);
                repeat (HELD_CYCLES) begin
                    @(negedge clk);
                    if (cpu_ready_o) begin
                        report_failure(
                            "CPU request accepted while its set or the buffer was busy.");
                    end
                end
                next_drive_slot(); // Valid stays high until a later resume line.
            end
            OP_CPU_RESUME: begin
                await_cpu_accept();
            end
            OP_FILL, OP_FILL_DROP: begin
                send_fill(op_mem[base+2][31:0], op_mem[base+3]);
                if (kind == OP_FILL) begin
                    if (!done_valid_o) begin
                        report_failure("No done pulse after a fill that retired a miss.");
                    end
                    check_word("done_word_o", done_word_o, op_mem[base+4][31:0]);
                end else if (done_valid_o) begin
                    report_failure("Done pulse after a fill that matched no entry.");
                end
            end
            OP_FWD: begin
                send_fwd(fwd_msg_t'(op_mem[base+1][2:0]), op_mem[base+2][31:0]);
            end
            default: begin
                report_failure("Unknown operation kind in the stimulus file.");
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (l2_mshr_top_inst.props_inst.any_failed) begin
            report_failure("A bound assertion on the stream handshakes failed.");
        end
        if (n_ops > 0 && cycle_count >= n_ops * CYCLES_PER_OP) begin
            report_failure("Timeout, the run went past its cycle limit.");
        end
    end

    initial begin
        int base;
        int gap;
        cpu_valid_i = 1'b0;
        cpu_msg_i = CPU_READ;
        cpu_addr_i = '0;
        cpu_word_i = '0;
        mem_valid_i = 1'b0;
        mem_addr_i = '0;
        mem_line_i = '0;
        fwd_valid_i = 1'b0;
        fwd_msg_i = FWD_INV;
        fwd_addr_i = '0;
        void'($urandom(32'h5d21_3fa5));
        for (int i = 0; i < FIELDS * MAX_OPS; i++) begin
            op_mem[i] = '1; // All ones marks the end of the file.
        end
        $readmemh("sim/l2_mshr_input.txt", op_mem);
        while (n_ops < MAX_OPS && op_mem[n_ops * FIELDS] !== '1) begin
            n_ops++;
        end
        if (n_ops == 0) begin
            report_failure("The stimulus file holds no operations.");
        end
        @(posedge rst);
        next_drive_slot();
        for (int op = 0; op < n_ops; op++) begin
            base = op * FIELDS;
            gap = int'($urandom_range(3, 0));
            // A held request is still valid, and a gap here could miss its ready pulse.
            if (int'(op_mem[base][7:0]) != OP_CPU_RESUME) begin
                repeat (gap) next_drive_slot();
            end
            run_op(base);
            check_stall("fwd_stall_o", fwd_stall_o, op_mem[base+5][0]);
            check_idx("fwd_stall_idx_o", fwd_stall_idx_o, op_mem[base+6][IDX_BITS-1:0]);
        end
        if (l2_mshr_top_inst.props_inst.any_failed) begin
            report_failure("A bound assertion on the stream handshakes failed.");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== sim/l2_mshr_input.txt ====
// kind msg addr data(cpu word, or fill line with word 3 first) done_word stall idx
// kind: 0 cpu, 1 cpu held back, 2 held cpu accepted, 3 fill, 4 unmatched fill, 5 forward
0 0 00012344 0 0 0 0
5 0 00012340 0 0 1 3
5 4 00012340 0 0 0 3
3 0 00012340 a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0 a1a1a1a1 0 3
0 1 00abcd58 deadbeef 0 0 3
5 2 00abcd50 0 0 1 3
3 0 00abcd50 0f0f0f0f1e1e1e1e2d2d2d2d3c3c3c3c deadbeef 1 3
4 0 0f0f0f00 77777777666666665555555544444444 0 1 3
5 0 0f0f0f00 0 0 1 3
0 0 00001060 0 0 1 3
1 1 00002064 12345678 0 1 3
3 0 00001060 b3b3b3b3b2b2b2b2b1b1b1b1b0b0b0b0 b0b0b0b0 1 3
2 0 0 0 0 1 3
3 0 00002060 c3c3c3c3c2c2c2c2c1c1c1c1c0c0c0c0 12345678 1 3
0 0 00003070 0 0 1 3
0 0 00004084 0 0 1 3
0 1 00005098 cafef00d 0 1 3
0 0 000060ac 0 0 1 3
1 0 000070b0 0 0 1 3
5 3 00004080 0 0 1 2
3 0 00004080 d3d3d3d3d2d2d2d2d1d1d1d1d0d0d0d0 d1d1d1d1 1 2
2 0 0 0 0 1 2
5 0 00005090 0 0 0 1
3 0 00003070 e3e3e3e3e2e2e2e2e1e1e1e1e0e0e0e0 e0e0e0e0 0 1
3 0 00005090 f3f3f3f3f2f2f2f2f1f1f1f1f0f0f0f0 cafef00d 0 1
3 0 000060a0 93939393929292929191919190909090 93939393 0 1
3 0 000070b0 83838383828282828181818180808080 80808080 0 1

// ==== l2_mshr_top.f ====
design/l2_msg_pkg.sv
design/l2_cache_pkg.sv
design/l2_reqs_if.sv
design/l2_reqs.sv
design/l2_req_ctrl.sv
design/l2_mshr_top.sv
sim/l2_mshr_clkgen.sv
sim/l2_mshr_properties.sv
sim/l2_mshr_tb.sv

// ==== Makefile ====
SIM       := verilator
FLAGS     := --binary --timing --assert
TOP       := l2_mshr_tb
FILELIST  := l2_mshr_top.f
BUILD_DIR := obj_dir

.PHONY: test clean help

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove the build directory $(BUILD_DIR)"
	@echo "  help   show this list"
